/* flist.f */
+incdir+hw
hw/udp_echo_pkg.sv
hw/udp_echo_regs.sv
hw/frame_rx_filter.sv
hw/frame_buffer.sv
hw/echo_tx.sv
hw/udp_echo_top.sv
verif/tb_udp_echo.sv

/* Bender.yml */
package:
  name: udp_echo

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/udp_echo_pkg.sv
      - hw/udp_echo_regs.sv
      - hw/frame_rx_filter.sv
      - hw/frame_buffer.sv
      - hw/echo_tx.sv
      - hw/udp_echo_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_udp_echo.sv

/* verif/tb_udp_echo.sv */
// UDP echo testbench with directed tests, frame builder and reply reference model
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defs.svh"

module tb_udp_echo
  import udp_echo_pkg::*;
();

  localparam int NUM_FRAMES = 11;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * (`UE_FRAME_MAX * 4 + 100) + 2000;
  localparam mac_addr_t PEER_MAC = 48'h3C_FD_FE_A1_B2_C3;
  localparam ip_addr_t  PEER_IP  = {8'd192, 8'd168, 8'd1, 8'd5};

  logic      clk;
  logic      rst;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  wb_addr_t  wb_adr;
  wb_data_t  wb_dat_w;
  wb_data_t  wb_dat_r;
  logic      wb_ack;
  byte_t     rx_data;
  logic      rx_valid;
  logic      rx_last;
  logic      rx_ready;
  byte_t     tx_data;
  logic      tx_valid;
  logic      tx_last;
  logic      tx_ready;
  byte_t     led;

  int        errors;
  integer    seed;
  logic      bp_on;
  ip_addr_t  cfg_ip;
  udp_port_t cfg_port;
  int        exp_echoed;
  int        exp_dropped;
  int        frames_built;
  byte_t     frame[$];
  byte_t     exp_data[$];
  bit        exp_last[$];
  byte_t     got_data[$];
  bit        got_last[$];

  udp_echo_top udp_echo_top_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_last  (rx_last),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_last  (tx_last),
    .tx_ready (tx_ready),
    .led      (led)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Sink side, random stalls only while back-pressure is on
  always @(posedge clk) begin
    logic [31:0] r;
    if (bp_on) begin
      r = $random(seed);
      tx_ready <= r[0];
    end else begin
      tx_ready <= 1'b1;
    end
  end

  // Collect transmitted bytes; sampled mid-cycle where the stream is stable
  always @(negedge clk) begin
    if (!rst && tx_valid) begin
      check("rx_ready", rx_ready, 1'b0);
      if (tx_ready) begin
        got_data.push_back(tx_data);
        got_last.push_back(tx_last);
      end
    end
  end

  task automatic wb_access(input bit we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waits;
    waits = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    @(negedge clk);
    while (!wb_ack) begin
      waits++;
      @(negedge clk);
    end
    rdat = wb_dat_r;
    check("wb_ack latency", waits, 1);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
    wb_data_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic reg_expect(input wb_addr_t adr, input wb_data_t exp, input string name);
    wb_data_t data;
    wb_access(1'b0, adr, '0, data);
    check(name, data, exp);
  endtask

  task automatic push_bytes(input logic [47:0] value, input int n);
    for (int k = n - 1; k >= 0; k--) begin
      frame.push_back(value[8*k +: 8]);
    end
  endtask

  // Ethernet II, IPv4 without options, UDP, then the payload
  task automatic build_frame(input logic [15:0] eth_type, input byte_t proto,
                             input ip_addr_t dst_ip, input udp_port_t dst_port,
                             input int pay_len, input bit rnd);
    logic [31:0] r;
    frame.delete();
    push_bytes(`UE_LOCAL_MAC, 6);
    push_bytes(PEER_MAC, 6);
    push_bytes(eth_type, 2);
    push_bytes(16'h4500, 2);
    push_bytes(28 + pay_len, 2);
    push_bytes(32'h1C46_4000, 4);
    push_bytes({8'h40, proto, 16'hB1E6}, 4);
    push_bytes(PEER_IP, 4);
    push_bytes(dst_ip, 4);
    push_bytes(16'h9C40 + frames_built, 2);
    push_bytes(dst_port, 2);
    push_bytes(8 + pay_len, 2);
    // Nonzero so the zeroed reply checksum shows
    push_bytes(16'h5A5A, 2);
    for (int i = 0; i < pay_len; i++) begin
      r = $random(seed);
      frame.push_back(rnd ? r[7:0] : 8'hA0 + i[7:0]);
    end
    frames_built++;
  endtask

  // Expected reply from the rewrite rule, appended to the expected stream
  task automatic model_reply();
    mac_addr_t local_mac;
    byte_t     b;
    local_mac = `UE_LOCAL_MAC;
    for (int i = 0; i < frame.size(); i++) begin
      b = frame[i];
      if (i < `UE_OFS_SRC_MAC) begin
        b = frame[i + `UE_OFS_SRC_MAC];
      end else if (i < `UE_OFS_SRC_MAC + 6) begin
        b = local_mac[8*(`UE_OFS_SRC_MAC + 5 - i) +: 8];
      end else if (i >= `UE_OFS_SRC_IP && i < `UE_OFS_SRC_IP + 4) begin
        b = cfg_ip[8*(`UE_OFS_SRC_IP + 3 - i) +: 8];
      end else if (i >= `UE_OFS_DST_IP && i < `UE_OFS_DST_IP + 4) begin
        b = frame[i - 4];
      end else if (i >= `UE_OFS_SRC_PORT && i < `UE_OFS_SRC_PORT + 2) begin
        b = cfg_port[8*(`UE_OFS_SRC_PORT + 1 - i) +: 8];
      end else if (i >= `UE_OFS_DST_PORT && i < `UE_OFS_DST_PORT + 2) begin
        b = frame[i - 2];
      end else if (i >= `UE_OFS_CSUM && i < `UE_OFS_CSUM + 2) begin
        b = 8'h00;
      end
      exp_data.push_back(b);
      exp_last.push_back(i == frame.size() - 1);
    end
  endtask

  task automatic send_frame();
    @(posedge clk);
    for (int i = 0; i < frame.size(); i++) begin
      rx_data  <= frame[i];
      rx_valid <= 1'b1;
      rx_last  <= (i == frame.size() - 1);
      @(negedge clk);
      while (!rx_ready) begin
        @(negedge clk);
      end
      @(posedge clk);
    end
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
  endtask

  task automatic send_dropped(input string name);
    send_frame();
    exp_dropped++;
    reg_expect(`UE_REG_DROPPED, exp_dropped, name);
    reg_expect(`UE_REG_ECHOED, exp_echoed, "echoed count");
  endtask

  task automatic compare_replies();
    while (got_data.size() < exp_data.size()) begin
      @(negedge clk);
    end
    for (int i = 0; i < exp_data.size(); i++) begin
      check($sformatf("tx_data[%0d]", i), got_data[i], exp_data[i]);
      check($sformatf("tx_last[%0d]", i), got_last[i], exp_last[i]);
    end
    repeat (4) @(posedge clk);
    check("reply byte count", got_data.size(), exp_data.size());
  endtask

  task automatic clear_streams();
    exp_data.delete();
    exp_last.delete();
    got_data.delete();
    got_last.delete();
  endtask

  task automatic test_registers();
    @(negedge clk);
    check("rx_ready", rx_ready, 1'b1);
    check("tx_valid", tx_valid, 1'b0);
    check("wb_ack", wb_ack, 1'b0);
    check("led", led, 8'h00);
    reg_expect(`UE_REG_CTRL, 32'd1, "ctrl");
    reg_expect(`UE_REG_LOCAL_IP, {8'd10, 8'd1, 8'd212, 8'd22}, "local_ip");
    reg_expect(`UE_REG_UDP_PORT, 32'd1234, "udp_port");
    reg_expect(`UE_REG_ECHOED, 32'd0, "echoed count");
    reg_expect(`UE_REG_DROPPED, 32'd0, "dropped count");
    cfg_ip   = {8'd192, 8'd168, 8'd1, 8'd50};
    cfg_port = 16'd5000;
    wb_write(`UE_REG_LOCAL_IP, cfg_ip);
    // Upper half of the port word is not stored
    wb_write(`UE_REG_UDP_PORT, {16'hBEEF, cfg_port});
    reg_expect(`UE_REG_LOCAL_IP, cfg_ip, "local_ip");
    reg_expect(`UE_REG_UDP_PORT, {16'h0000, cfg_port}, "udp_port");
    wb_write(`UE_REG_ECHOED, 32'h1234_5678);
    wb_write(`UE_REG_DROPPED, 32'hFFFF_FFFF);
    wb_write(3'd7, 32'hFFFF_FFFF);
    reg_expect(`UE_REG_ECHOED, 32'd0, "echoed count");
    reg_expect(`UE_REG_DROPPED, 32'd0, "dropped count");
    reg_expect(3'd5, 32'd0, "unmapped word 5");
    reg_expect(3'd7, 32'd0, "unmapped word 7");
  endtask

  task automatic test_echo();
    clear_streams();
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port, 20, 1'b0);
    model_reply();
    send_frame();
    compare_replies();
    check("led", led, frame[`UE_HDR_LEN]);
    exp_echoed++;
    reg_expect(`UE_REG_ECHOED, exp_echoed, "echoed count");
  endtask

  task automatic test_mismatch();
    clear_streams();
    build_frame(16'h86DD, `UE_PROTO_UDP, cfg_ip, cfg_port, 16, 1'b0);
    send_dropped("dropped count after ethertype mismatch");
    build_frame(`UE_ETHERTYPE_IPV4, 8'd6, cfg_ip, cfg_port, 16, 1'b0);
    send_dropped("dropped count after protocol mismatch");
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip ^ 32'h1, cfg_port, 16, 1'b0);
    send_dropped("dropped count after IP mismatch");
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port + 16'd1, 16, 1'b0);
    send_dropped("dropped count after port mismatch");
    repeat (8) @(posedge clk);
    check("reply byte count", got_data.size(), 0);
  endtask

  task automatic test_invalid();
    clear_streams();
    wb_write(`UE_REG_CTRL, 32'd0);
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port, 20, 1'b0);
    send_dropped("dropped count while disabled");
    wb_write(`UE_REG_CTRL, 32'd1);
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port, 0, 1'b0);
    while (frame.size() > 30) begin
      void'(frame.pop_back());
    end
    send_dropped("dropped count after short frame");
    build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port, 258, 1'b0);
    send_dropped("dropped count after long frame");
    repeat (8) @(posedge clk);
    check("reply byte count", got_data.size(), 0);
  endtask

  task automatic test_backpressure();
    byte_t       stim[$];
    int          lens[$];
    int          pos;
    byte_t       last_led;
    logic [31:0] r;
    clear_streams();
    // All random draws for the frames happen before the sink starts stalling
    for (int f = 0; f < 3; f++) begin
      r = $random(seed);
      build_frame(`UE_ETHERTYPE_IPV4, `UE_PROTO_UDP, cfg_ip, cfg_port, 8 + r[5:0], 1'b1);
      model_reply();
      last_led = frame[`UE_HDR_LEN];
      lens.push_back(frame.size());
      foreach (frame[i]) begin
        stim.push_back(frame[i]);
      end
    end
    bp_on <= 1'b1;
    pos = 0;
    for (int f = 0; f < 3; f++) begin
      frame.delete();
      for (int k = 0; k < lens[f]; k++) begin
        frame.push_back(stim[pos]);
        pos++;
      end
      send_frame();
    end
    compare_replies();
    bp_on <= 1'b0;
    check("led", led, last_led);
    exp_echoed += 3;
    reg_expect(`UE_REG_ECHOED, exp_echoed, "echoed count");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    rx_data      = '0;
    rx_valid     = 1'b0;
    rx_last      = 1'b0;
    tx_ready     = 1'b1;
    bp_on        = 1'b0;
    seed         = 92;
    errors       = 0;
    exp_echoed   = 0;
    exp_dropped  = 0;
    frames_built = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    test_echo();
    test_mismatch();
    test_invalid();
    test_backpressure();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/udp_echo_top.sv */
// UDP echo responder top joining register block, receive filter, frame buffer and transmitter
`timescale 1ns/1ns
`default_nettype none

module udp_echo_top
  import udp_echo_pkg::*;
(
  input  wire            clk,
  input  wire            rst,
  input  wire            wb_cyc,
  input  wire            wb_stb,
  input  wire            wb_we,
  input  wire wb_addr_t  wb_adr,
  input  wire wb_data_t  wb_dat_w,
  output wb_data_t       wb_dat_r,
  output logic           wb_ack,
  input  wire byte_t     rx_data,
  input  wire            rx_valid,
  input  wire            rx_last,
  output logic           rx_ready,
  output byte_t          tx_data,
  output logic           tx_valid,
  output logic           tx_last,
  input  wire            tx_ready,
  output byte_t          led
);

  // Configuration and status
  ip_addr_t   local_ip;
  udp_port_t  udp_port;
  logic       enable;
  logic       echoed;
  logic       dropped;

  // Buffer traffic and frame handover
  logic       wr_en;
  frame_len_t wr_addr;
  byte_t      wr_data;
  frame_len_t rd_addr;
  byte_t      rd_data;
  logic       claim;
  logic       frame_release;
  logic       owned;
  frame_len_t frame_len;
  mac_addr_t  peer_mac;
  ip_addr_t   peer_ip;

  udp_echo_regs udp_echo_regs_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .local_ip (local_ip),
    .udp_port (udp_port),
    .enable   (enable),
    .echoed   (echoed),
    .dropped  (dropped)
  );

  frame_rx_filter frame_rx_filter_i (
    .clk       (clk),
    .rst       (rst),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .local_ip  (local_ip),
    .udp_port  (udp_port),
    .enable    (enable),
    .owned     (owned),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .claim     (claim),
    .frame_len (frame_len),
    .peer_mac  (peer_mac),
    .peer_ip   (peer_ip),
    .echoed    (echoed),
    .dropped   (dropped)
  );

  frame_buffer frame_buffer_i (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .claim         (claim),
    .frame_release (frame_release),
    .owned         (owned)
  );

  echo_tx echo_tx_i (
    .clk           (clk),
    .rst           (rst),
    .claim         (claim),
    .frame_len     (frame_len),
    .peer_mac      (peer_mac),
    .peer_ip       (peer_ip),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .frame_release (frame_release),
    .local_ip      (local_ip),
    .udp_port      (udp_port),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .tx_last       (tx_last),
    .led           (led)
  );

endmodule

`default_nettype wire

/* hw/echo_tx.sv */
// Echo transmitter that replays the buffered frame with the reply header rewrite
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defs.svh"

module echo_tx
  import udp_echo_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              claim,
  input  wire frame_len_t  frame_len,
  input  wire mac_addr_t   peer_mac,
  input  wire ip_addr_t    peer_ip,
  output frame_len_t       rd_addr,
  input  wire byte_t       rd_data,
  output logic             frame_release,
  input  wire ip_addr_t    local_ip,
  input  wire udp_port_t   udp_port,
  output byte_t            tx_data,
  output logic             tx_valid,
  input  wire              tx_ready,
  output logic             tx_last,
  output byte_t            led
);

  localparam mac_addr_t LOCAL_MAC = `UE_LOCAL_MAC;

  tx_state_t  state;
  frame_len_t idx;
  frame_len_t nxt;
  frame_len_t len_q;
  mac_addr_t  peer_mac_q;
  ip_addr_t   peer_ip_q;
  logic       fire;

  assign tx_valid      = (state == TX_SEND);
  assign tx_last       = tx_valid && (idx == len_q - 1'b1);
  assign fire          = tx_valid && tx_ready;
  assign frame_release = fire && tx_last;

  // Address of the byte shown next cycle; a stall re-reads the same byte.
  // Destination port bytes are fetched from the source port position.
  always_comb begin
    nxt = fire ? idx + 1'b1 : idx;
    if (nxt >= `UE_OFS_DST_PORT && nxt < `UE_OFS_DST_PORT + 2) begin
      rd_addr = frame_len_t'(nxt - (`UE_OFS_DST_PORT - `UE_OFS_SRC_PORT));
    end else begin
      rd_addr = nxt;
    end
  end

  // Reply header rewrite
  always_comb begin
    tx_data = rd_data;
    if (idx < `UE_OFS_SRC_MAC) begin
      tx_data = peer_mac_q[8*(`UE_OFS_DST_MAC + 5 - idx) +: 8];
    end else if (idx < `UE_OFS_SRC_MAC + 6) begin
      tx_data = LOCAL_MAC[8*(`UE_OFS_SRC_MAC + 5 - idx) +: 8];
    end else if (idx >= `UE_OFS_SRC_IP && idx < `UE_OFS_SRC_IP + 4) begin
      tx_data = local_ip[8*(`UE_OFS_SRC_IP + 3 - idx) +: 8];
    end else if (idx >= `UE_OFS_DST_IP && idx < `UE_OFS_DST_IP + 4) begin
      tx_data = peer_ip_q[8*(`UE_OFS_DST_IP + 3 - idx) +: 8];
    end else if (idx >= `UE_OFS_SRC_PORT && idx < `UE_OFS_SRC_PORT + 2) begin
      tx_data = udp_port[8*(`UE_OFS_SRC_PORT + 1 - idx) +: 8];
    end else if (idx >= `UE_OFS_CSUM && idx < `UE_OFS_CSUM + 2) begin
      tx_data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && claim) begin
      len_q      <= frame_len;
      peer_mac_q <= peer_mac;
      peer_ip_q  <= peer_ip;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TX_IDLE;
      idx   <= '0;
      led   <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (claim) begin
            state <= TX_FETCH;
            idx   <= '0;
          end
        end
        // Wait out the buffer read latency
        TX_FETCH: begin
          state <= TX_SEND;
        end
        TX_SEND: begin
          if (fire) begin
            idx <= idx + 1'b1;
            if (idx == `UE_HDR_LEN) begin
              led <= tx_data;
            end
            if (tx_last) begin
              state <= TX_IDLE;
            end
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  // Stalled output holds, which relies on the buffer re-read
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=> $stable(tx_data) && $stable(tx_last)
  );

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
// Single-frame byte buffer with an ownership flag handed between receive and transmit
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defs.svh"

module frame_buffer
  import udp_echo_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              wr_en,
  input  wire frame_len_t  wr_addr,
  input  wire byte_t       wr_data,
  input  wire frame_len_t  rd_addr,
  output byte_t            rd_data,
  input  wire              claim,
  input  wire              frame_release,
  output logic             owned
);

  localparam int AW = $clog2(`UE_FRAME_MAX);

  byte_t mem [`UE_FRAME_MAX];

  // Synchronous read, one cycle latency
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr[AW-1:0]] <= wr_data;
    end
    rd_data <= mem[rd_addr[AW-1:0]];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      owned <= 1'b0;
    end else if (claim) begin
      owned <= 1'b1;
    end else if (frame_release) begin
      owned <= 1'b0;
    end
  end

  // Receive side waits for the transmitter before a new claim
  a_claim_free: assert property (
    @(posedge clk) disable iff (rst)
    claim |-> !owned
  );

endmodule

`default_nettype wire

/* hw/frame_rx_filter.sv */
// Receive filter that buffers an incoming frame and judges it for echo at its last byte
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defs.svh"

module frame_rx_filter
  import udp_echo_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire byte_t      rx_data,
  input  wire             rx_valid,
  input  wire             rx_last,
  output logic            rx_ready,
  input  wire ip_addr_t   local_ip,
  input  wire udp_port_t  udp_port,
  input  wire             enable,
  input  wire             owned,
  output logic            wr_en,
  output frame_len_t      wr_addr,
  output byte_t           wr_data,
  output logic            claim,
  output frame_len_t      frame_len,
  output mac_addr_t       peer_mac,
  output ip_addr_t        peer_ip,
  output logic            echoed,
  output logic            dropped
);

  localparam frame_len_t LEN_MAX = frame_len_t'(`UE_FRAME_MAX);

  rx_state_t   state;
  frame_len_t  cnt;
  frame_len_t  idx;
  logic        accept;
  logic        match;
  logic [15:0] eth_type;
  byte_t       proto;
  ip_addr_t    dst_ip;
  udp_port_t   dst_port;

  // Ready again as soon as the transmitter gives the buffer back
  assign rx_ready = (state != RX_WAIT_TX) || (!owned && !claim);
  assign accept   = rx_valid && rx_ready;
  assign idx      = (state == RX_RECV) ? cnt : '0;

  // Bytes past the buffer end are counted but not stored
  assign wr_en   = accept && (idx != LEN_MAX);
  assign wr_addr = idx;
  assign wr_data = rx_data;

  // idx is the last byte's index when judged
  assign match = enable &&
                 (idx >= frame_len_t'(`UE_HDR_LEN - 1)) &&
                 (idx != LEN_MAX) &&
                 (eth_type == `UE_ETHERTYPE_IPV4) &&
                 (proto == `UE_PROTO_UDP) &&
                 (dst_ip == local_ip) &&
                 (dst_port == udp_port);

  // Byte count and header fields, shifted in MSB first
  always_ff @(posedge clk) begin
    if (accept) begin
      cnt <= (idx == LEN_MAX) ? idx : idx + 1'b1;
      if (rx_last) begin
        frame_len <= idx + 1'b1;
      end
      if (idx >= `UE_OFS_SRC_MAC && idx < `UE_OFS_SRC_MAC + 6) begin
        peer_mac <= {peer_mac[39:0], rx_data};
      end
      if (idx >= `UE_OFS_TYPE && idx < `UE_OFS_TYPE + 2) begin
        eth_type <= {eth_type[7:0], rx_data};
      end
      if (idx == `UE_OFS_PROTO) begin
        proto <= rx_data;
      end
      if (idx >= `UE_OFS_SRC_IP && idx < `UE_OFS_SRC_IP + 4) begin
        peer_ip <= {peer_ip[23:0], rx_data};
      end
      if (idx >= `UE_OFS_DST_IP && idx < `UE_OFS_DST_IP + 4) begin
        dst_ip <= {dst_ip[23:0], rx_data};
      end
      if (idx >= `UE_OFS_DST_PORT && idx < `UE_OFS_DST_PORT + 2) begin
        dst_port <= {dst_port[7:0], rx_data};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= RX_IDLE;
      claim   <= 1'b0;
      echoed  <= 1'b0;
      dropped <= 1'b0;
    end else begin
      claim   <= 1'b0;
      echoed  <= 1'b0;
      dropped <= 1'b0;
      if (accept) begin
        if (!rx_last) begin
          state <= RX_RECV;
        end else if (match) begin
          state  <= RX_WAIT_TX;
          claim  <= 1'b1;
          echoed <= 1'b1;
        end else begin
          state   <= RX_IDLE;
          dropped <= 1'b1;
        end
      end else if (state == RX_WAIT_TX && !owned && !claim) begin
        state <= RX_IDLE;
      end
    end
  end

  // Buffer is never overwritten while a reply is pending
  a_no_write_owned: assert property (
    @(posedge clk) disable iff (rst)
    owned |-> !wr_en
  );

endmodule

`default_nettype wire

/* hw/udp_echo_regs.sv */
// UDP echo register block on Wishbone classic with configuration and frame counters
`timescale 1ns/1ns
`default_nettype none

`include "udp_echo_defs.svh"

module udp_echo_regs
  import udp_echo_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             wb_cyc,
  input  wire             wb_stb,
  input  wire             wb_we,
  input  wire wb_addr_t   wb_adr,
  input  wire wb_data_t   wb_dat_w,
  output wb_data_t        wb_dat_r,
  output logic            wb_ack,
  output ip_addr_t        local_ip,
  output udp_port_t       udp_port,
  output logic            enable,
  input  wire             echoed,
  input  wire             dropped
);

  wb_data_t echoed_cnt;
  wb_data_t dropped_cnt;
  logic     wb_req;

  // New request only while no acknowledge is out
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      enable   <= `UE_RST_ENABLE;
      local_ip <= `UE_RST_LOCAL_IP;
      udp_port <= `UE_RST_UDP_PORT;
    end else begin
      wb_ack <= wb_req;
      if (wb_req && wb_we) begin
        case (wb_adr)
          `UE_REG_CTRL: begin
            enable <= wb_dat_w[0];
          end
          `UE_REG_LOCAL_IP: begin
            local_ip <= wb_dat_w;
          end
          `UE_REG_UDP_PORT: begin
            udp_port <= wb_dat_w[15:0];
          end
          // Counters and unmapped words ignore writes
          default: begin
          end
        endcase
      end
    end
  end

  // Frame counters
  always_ff @(posedge clk) begin
    if (rst) begin
      echoed_cnt  <= '0;
      dropped_cnt <= '0;
    end else begin
      if (echoed) begin
        echoed_cnt <= echoed_cnt + 1'b1;
      end
      if (dropped) begin
        dropped_cnt <= dropped_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (wb_adr)
      `UE_REG_CTRL:     wb_dat_r = {31'b0, enable};
      `UE_REG_LOCAL_IP: wb_dat_r = local_ip;
      `UE_REG_UDP_PORT: wb_dat_r = {16'b0, udp_port};
      `UE_REG_ECHOED:   wb_dat_r = echoed_cnt;
      `UE_REG_DROPPED:  wb_dat_r = dropped_cnt;
      default:          wb_dat_r = '0;
    endcase
  end

  // Acknowledge only lands on a cycle and strobe still held by the host
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(wb_ack) |-> wb_cyc && wb_stb
  );

endmodule

`default_nettype wire

/* hw/udp_echo_pkg.sv */
// UDP echo shared types for stream, address and state encodings
`default_nettype none

`include "udp_echo_defs.svh"

package udp_echo_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // Extra bit so a full buffer length fits
  typedef logic [$clog2(`UE_FRAME_MAX):0] frame_len_t;

  typedef logic [31:0] wb_data_t;
  typedef logic [2:0]  wb_addr_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_RECV,
    RX_WAIT_TX
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FETCH,
    TX_SEND
  } tx_state_t;

endpackage

`default_nettype wire

/* hw/udp_echo_defs.svh */
// UDP echo constants for the local address, buffer size, header layout and register map
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// Source address of every reply
`define UE_LOCAL_MAC 48'h02_00_00_00_00_00

// One frame of buffering
`define UE_FRAME_MAX 256

// Ethernet II + IPv4 without options + UDP
`define UE_HDR_LEN        42
`define UE_ETHERTYPE_IPV4 16'h0800
`define UE_PROTO_UDP      8'd17

// Byte offsets into the frame
`define UE_OFS_DST_MAC  0
`define UE_OFS_SRC_MAC  6
`define UE_OFS_TYPE     12
`define UE_OFS_PROTO    23
`define UE_OFS_SRC_IP   26
`define UE_OFS_DST_IP   30
`define UE_OFS_SRC_PORT 34
`define UE_OFS_DST_PORT 36
`define UE_OFS_CSUM     40

// Register word addresses
`define UE_REG_CTRL     3'd0
`define UE_REG_LOCAL_IP 3'd1
`define UE_REG_UDP_PORT 3'd2
`define UE_REG_ECHOED   3'd3
`define UE_REG_DROPPED  3'd4

// Register reset values, local IP is 10.1.212.22
`define UE_RST_ENABLE   1'b1
`define UE_RST_LOCAL_IP 32'h0A01_D416
`define UE_RST_UDP_PORT 16'd1234

`endif
